// ==== logic/bpu_types_pkg.sv ====
package bpu_types_pkg;

    // Byte address of an instruction.
    localparam int unsigned ADDR_W = 32;
    typedef logic [ADDR_W-1:0] addr_t;

    // Instructions are word aligned, so the low bits never index a table.
    localparam int unsigned ALIGN_BITS = 2;

    // Bits left once the alignment is dropped; split into index and tag.
    localparam int unsigned WORD_W = ADDR_W - ALIGN_BITS;

    // Distance from the first fetch slot to the second.
    localparam int unsigned FETCH_STEP = 4;

    // Widest supported direction counter.
    localparam int unsigned CTR_W = 4;
    typedef logic [CTR_W-1:0] ctr_t; // Only the low COUNTER_BITS are live.

endpackage

// ==== logic/bpu_ctrl_pkg.sv ====
package bpu_ctrl_pkg;

    // Class of the control transfer resolved in execute.
    typedef enum logic [2:0] {
        XFER_NONE   = 3'd0, // Nothing to train.
        XFER_BRANCH = 3'd1, // Conditional branch.
        XFER_J      = 3'd2, // Direct jump.
        XFER_JAL    = 3'd3, // Direct call, pushes the return site.
        XFER_JALR   = 3'd4, // Indirect call, pushes the return site.
        XFER_JR_RA  = 3'd5  // Return through ra.
    } xfer_kind_e;

    // States of the default 2-bit direction counter.
    // The top bit is the prediction.
    typedef enum logic [1:0] {
        STRONG_NOT_TAKEN = 2'b00,
        WEAK_NOT_TAKEN   = 2'b01,
        WEAK_TAKEN       = 2'b10,
        STRONG_TAKEN     = 2'b11
    } dir_state_e;

endpackage

// ==== logic/bpu_update_if.sv ====
`timescale 1ns/1ps

// Training bundle from execute. Valid every cycle; kind XFER_NONE is idle.
interface bpu_update_if;

    bpu_types_pkg::addr_t     exe_pc;   // Address of the resolved instruction.
    bpu_types_pkg::addr_t     dest_pc;  // Resolved target.
    bpu_types_pkg::addr_t     ret_pc;   // Return site for calls.
    bpu_ctrl_pkg::xfer_kind_e kind;
    logic                     is_taken;

    modport src (
        output exe_pc,
        output dest_pc,
        output ret_pc,
        output kind,
        output is_taken
    );

    modport sink (
        input exe_pc,
        input dest_pc,
        input ret_pc,
        input kind,
        input is_taken
    );

endinterface

// ==== logic/bht.sv ====
`timescale 1ns/1ps

module bht #(
    parameter int unsigned COUNTER_BITS = 2,
    parameter int unsigned BHT_ENTRIES  = 64
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  bpu_types_pkg::addr_t f1_pc,
    bpu_update_if.sink           upd,
    output logic                 hit,
    output logic                 hit_pc,
    output bpu_types_pkg::addr_t target,
    output logic                 is_jump,
    output logic                 dir_taken
);

    localparam int unsigned IDX_W = $clog2(BHT_ENTRIES);
    localparam int unsigned TAG_W = bpu_types_pkg::WORD_W - IDX_W;
    localparam int unsigned LSB   = bpu_types_pkg::ALIGN_BITS;

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [TAG_W-1:0] tag_t;

    localparam bpu_types_pkg::ctr_t CTR_MAX =
        bpu_types_pkg::ctr_t'((1 << COUNTER_BITS) - 1);
    // Weak taken is the 2-bit code scaled up to the counter width.
    localparam bpu_types_pkg::ctr_t CTR_WEAK_T = (COUNTER_BITS > 1) ?
        bpu_types_pkg::ctr_t'(bpu_ctrl_pkg::WEAK_TAKEN) << (COUNTER_BITS - 2) :
        bpu_types_pkg::ctr_t'(1);
    localparam bpu_types_pkg::ctr_t CTR_WEAK_NT = CTR_WEAK_T - 1'b1;

    function automatic idx_t idx_of(input bpu_types_pkg::addr_t a);
        return a[LSB +: IDX_W];
    endfunction

    function automatic tag_t tag_of(input bpu_types_pkg::addr_t a);
        return a[bpu_types_pkg::ADDR_W-1 -: TAG_W];
    endfunction

    logic                 valid_q  [BHT_ENTRIES];
    tag_t                 tag_q    [BHT_ENTRIES];
    bpu_types_pkg::addr_t target_q [BHT_ENTRIES];
    logic                 jump_q   [BHT_ENTRIES];
    bpu_types_pkg::ctr_t  ctr_q    [BHT_ENTRIES];

    bpu_types_pkg::addr_t pc_next;
    idx_t                 idx0, idx1, sel;
    logic                 hit0, hit1;

    idx_t                 upd_idx;
    tag_t                 upd_tag;
    logic                 upd_write, upd_jump, upd_match;
    bpu_types_pkg::ctr_t  ctr_next;

    // Probe both fetch slots.
    assign pc_next = f1_pc + bpu_types_pkg::ADDR_W'(bpu_types_pkg::FETCH_STEP);
    assign idx0    = idx_of(f1_pc);
    assign idx1    = idx_of(pc_next);
    assign hit0    = valid_q[idx0] && (tag_q[idx0] == tag_of(f1_pc));
    assign hit1    = valid_q[idx1] && (tag_q[idx1] == tag_of(pc_next));

    assign hit       = hit0 || hit1;
    assign hit_pc    = hit0;                // First slot wins.
    assign sel       = hit0 ? idx0 : idx1;
    assign target    = target_q[sel];
    assign is_jump   = jump_q[sel];
    assign dir_taken = ctr_q[sel][COUNTER_BITS-1];

    assign upd_write = (upd.kind == bpu_ctrl_pkg::XFER_BRANCH) ||
                       (upd.kind == bpu_ctrl_pkg::XFER_J) ||
                       (upd.kind == bpu_ctrl_pkg::XFER_JAL);
    assign upd_jump  = (upd.kind == bpu_ctrl_pkg::XFER_J) ||
                       (upd.kind == bpu_ctrl_pkg::XFER_JAL);
    assign upd_idx   = idx_of(upd.exe_pc);
    assign upd_tag   = tag_of(upd.exe_pc);
    assign upd_match = valid_q[upd_idx] && (tag_q[upd_idx] == upd_tag);

    always_comb begin
        ctr_next = ctr_q[upd_idx];
        if (upd_jump) begin
            ctr_next = CTR_MAX;
        end else if (!upd_match) begin
            ctr_next = upd.is_taken ? CTR_WEAK_T : CTR_WEAK_NT; // Fresh entry.
        end else if (upd.is_taken && (ctr_q[upd_idx] != CTR_MAX)) begin
            ctr_next = ctr_q[upd_idx] + 1'b1;
        end else if (!upd.is_taken && (ctr_q[upd_idx] != '0)) begin
            ctr_next = ctr_q[upd_idx] - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
                ctr_q[i]   <= CTR_WEAK_NT;
            end
        end else if (upd_write) begin
            valid_q[upd_idx] <= 1'b1;
            ctr_q[upd_idx]   <= ctr_next;
        end
    end

    always_ff @(posedge clk) begin
        if (upd_write) begin
            tag_q[upd_idx]    <= upd_tag;
            target_q[upd_idx] <= upd.dest_pc;
            jump_q[upd_idx]   <= upd_jump;
        end
    end

    // A trained counter stays inside its configured width.
    a_ctr_range: assert property (@(posedge clk) disable iff (!rst_n)
        upd_write |=> ctr_q[$past(upd_idx)] <= CTR_MAX)
        else $error("bht counter left its range");

endmodule

// ==== logic/ras.sv ====
`timescale 1ns/1ps

module ras #(
    parameter int unsigned RAS_DEPTH = 8
) (
    input  logic                 clk,
    input  logic                 rst_n,
    bpu_update_if.sink           upd,
    input  logic                 pop,
    output bpu_types_pkg::addr_t top,
    output logic                 fail
);

    localparam int unsigned PTR_W = (RAS_DEPTH > 1) ? $clog2(RAS_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(RAS_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    localparam ptr_t LAST = ptr_t'(RAS_DEPTH - 1);
    localparam cnt_t FULL = cnt_t'(RAS_DEPTH);

    bpu_types_pkg::addr_t stack_q [RAS_DEPTH];
    ptr_t                 ptr_q;   // Next free slot.
    cnt_t                 count_q;
    ptr_t                 top_idx, ptr_inc;
    logic                 push, empty, pop_ok;

    assign push    = (upd.kind == bpu_ctrl_pkg::XFER_JAL) ||
                     (upd.kind == bpu_ctrl_pkg::XFER_JALR);
    assign empty   = (count_q == '0);
    assign pop_ok  = pop && !empty;
    assign top_idx = (ptr_q == '0) ? LAST : ptr_q - 1'b1;
    assign ptr_inc = (ptr_q == LAST) ? '0 : ptr_q + 1'b1;

    assign top  = empty ? '0 : stack_q[top_idx];
    assign fail = pop && empty;

    // Push with pop keeps pointer and count; only the top is rewritten.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr_q   <= '0;
            count_q <= '0;
        end else if (push && !pop_ok) begin
            ptr_q <= ptr_inc;
            if (count_q != FULL) begin
                count_q <= count_q + 1'b1; // Full stack drops the oldest.
            end
        end else if (pop_ok && !push) begin
            ptr_q   <= top_idx;
            count_q <= count_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            if (pop_ok) begin
                stack_q[top_idx] <= upd.ret_pc;
            end else begin
                stack_q[ptr_q] <= upd.ret_pc;
            end
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        count_q <= FULL)
        else $error("ras count exceeds depth");

    // Swap case leaves the new return site on top.
    a_swap_top: assert property (@(posedge clk) disable iff (!rst_n)
        (push && pop_ok) |=> top == $past(upd.ret_pc))
        else $error("ras push with pop lost the new top");

endmodule

// ==== logic/rpct.sv ====
`timescale 1ns/1ps

module rpct #(
    parameter int unsigned RPCT_ENTRIES = 16
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  bpu_types_pkg::addr_t f1_pc,
    bpu_update_if.sink           upd,
    output logic                 hit,
    output logic                 hit_pc
);

    localparam int unsigned IDX_W = $clog2(RPCT_ENTRIES);
    localparam int unsigned TAG_W = bpu_types_pkg::WORD_W - IDX_W;
    localparam int unsigned LSB   = bpu_types_pkg::ALIGN_BITS;

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [TAG_W-1:0] tag_t;

    function automatic idx_t idx_of(input bpu_types_pkg::addr_t a);
        return a[LSB +: IDX_W];
    endfunction

    function automatic tag_t tag_of(input bpu_types_pkg::addr_t a);
        return a[bpu_types_pkg::ADDR_W-1 -: TAG_W];
    endfunction

    logic                 valid_q [RPCT_ENTRIES];
    tag_t                 tag_q   [RPCT_ENTRIES];

    bpu_types_pkg::addr_t pc_next;
    idx_t                 idx0, idx1, upd_idx;
    tag_t                 upd_tag;
    logic                 hit0, hit1, upd_write;

    assign pc_next = f1_pc + bpu_types_pkg::ADDR_W'(bpu_types_pkg::FETCH_STEP);
    assign idx0    = idx_of(f1_pc);
    assign idx1    = idx_of(pc_next);
    assign hit0    = valid_q[idx0] && (tag_q[idx0] == tag_of(f1_pc));
    assign hit1    = valid_q[idx1] && (tag_q[idx1] == tag_of(pc_next));

    assign hit    = hit0 || hit1;
    assign hit_pc = hit0;

    assign upd_write = (upd.kind == bpu_ctrl_pkg::XFER_JR_RA);
    assign upd_idx   = idx_of(upd.exe_pc);
    assign upd_tag   = tag_of(upd.exe_pc);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < RPCT_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (upd_write) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (upd_write) begin
            tag_q[upd_idx] <= upd_tag;
        end
    end

    a_hit_pc: assert property (@(posedge clk) disable iff (!rst_n)
        hit_pc |-> hit)
        else $error("rpct hit_pc without hit");

endmodule

// ==== logic/bpu.sv ====
`timescale 1ns/1ps

module bpu #(
    parameter int unsigned COUNTER_BITS = 2,
    parameter int unsigned BHT_ENTRIES  = 64,
    parameter int unsigned RAS_DEPTH    = 8,
    parameter int unsigned RPCT_ENTRIES = 16
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  bpu_types_pkg::addr_t     f1_pc,
    input  logic                     jr_ra_decode,
    input  bpu_types_pkg::addr_t     exe_pc,
    input  bpu_types_pkg::addr_t     dest_pc,
    input  bpu_types_pkg::addr_t     ret_pc,
    input  bpu_ctrl_pkg::xfer_kind_e exe_kind,
    input  logic                     is_taken,
    output logic                     f1_taken,
    output logic                     pos,
    output bpu_types_pkg::addr_t     pre_pc,
    output logic                     jr_ra_fail
);

    logic                 bht_hit, bht_hit_pc, bht_jump, bht_dir;
    bpu_types_pkg::addr_t bht_target;
    logic                 rpct_hit, rpct_hit_pc;
    logic                 ras_pop, ras_fail;
    bpu_types_pkg::addr_t ras_top;

    bpu_update_if upd_bus ();

    assign upd_bus.exe_pc   = exe_pc;
    assign upd_bus.dest_pc  = dest_pc;
    assign upd_bus.ret_pc   = ret_pc;
    assign upd_bus.kind     = exe_kind;
    assign upd_bus.is_taken = is_taken;

    bht #(
        .COUNTER_BITS (COUNTER_BITS),
        .BHT_ENTRIES  (BHT_ENTRIES)
    ) u_bht (
        .clk       (clk),
        .rst_n     (rst_n),
        .f1_pc     (f1_pc),
        .upd       (upd_bus.sink),
        .hit       (bht_hit),
        .hit_pc    (bht_hit_pc),
        .target    (bht_target),
        .is_jump   (bht_jump),
        .dir_taken (bht_dir)
    );

    // Decode request and fetch-time return share one pop.
    assign ras_pop = jr_ra_decode || rpct_hit;

    ras #(
        .RAS_DEPTH (RAS_DEPTH)
    ) u_ras (
        .clk   (clk),
        .rst_n (rst_n),
        .upd   (upd_bus.sink),
        .pop   (ras_pop),
        .top   (ras_top),
        .fail  (ras_fail)
    );

    rpct #(
        .RPCT_ENTRIES (RPCT_ENTRIES)
    ) u_rpct (
        .clk    (clk),
        .rst_n  (rst_n),
        .f1_pc  (f1_pc),
        .upd    (upd_bus.sink),
        .hit    (rpct_hit),
        .hit_pc (rpct_hit_pc)
    );

    always_comb begin
        pre_pc = '0;
        pos    = 1'b0;
        if (jr_ra_decode) begin
            pre_pc = ras_top;
        end else if (bht_hit) begin
            pre_pc = bht_target;
        end else if (rpct_hit) begin
            pre_pc = ras_top;
        end
        // Slot of the fetch-side hit that supplies the target.
        if (bht_hit) begin
            pos = bht_hit_pc;
        end else if (rpct_hit) begin
            pos = rpct_hit_pc;
        end
    end

    always_comb begin
        f1_taken = 1'b0;
        if (rpct_hit && !ras_fail) begin
            f1_taken = 1'b1;
        end else if (bht_hit) begin
            f1_taken = bht_jump || bht_dir; // Jumps always go.
        end
    end

    assign jr_ra_fail = ras_fail;

    a_pos_needs_hit: assert property (@(posedge clk) disable iff (!rst_n)
        pos |-> (bht_hit || rpct_hit))
        else $error("pos high with no predictor hit");

endmodule

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real         PERIOD_NS    = 4.0,
    parameter int unsigned RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // Release lands 1 ns after an edge, like the stimulus.
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

// ==== testbench/tb_bpu.sv ====
`timescale 1ns/1ps

module tb_bpu;

    localparam int unsigned BHT_N       = 64;
    localparam int unsigned RPCT_N      = 16;
    localparam int unsigned RAS_N       = 8;
    localparam int unsigned RESET_LIMIT = 40;
    localparam bpu_types_pkg::addr_t IDLE = 32'h0000_9000; // Misses every trained entry.

    typedef struct {
        bpu_types_pkg::addr_t     f1_pc;
        logic                     dec;
        bpu_types_pkg::addr_t     exe_pc;
        bpu_types_pkg::addr_t     dest_pc;
        bpu_types_pkg::addr_t     ret_pc;
        bpu_ctrl_pkg::xfer_kind_e kind;
        logic                     taken;
        logic                     from_model;
        logic                     exp_taken;
        logic                     exp_pos;
        bpu_types_pkg::addr_t     exp_pre;
        logic                     exp_fail;
    } step_t;

    logic clk, rst_n;
    bpu_types_pkg::addr_t     f1_pc, exe_pc, dest_pc, ret_pc, pre_pc;
    bpu_ctrl_pkg::xfer_kind_e exe_kind;
    logic jr_ra_decode, is_taken, f1_taken, pos, jr_ra_fail;

    step_t       steps[$];
    int unsigned errors = 0;
    int unsigned checks = 0;
    int unsigned cur_step;
    logic [31:0] rand_state = 32'h368f;

    // Reference state.
    logic                     m_valid [BHT_N];
    bpu_types_pkg::addr_t     m_pc    [BHT_N];
    bpu_types_pkg::addr_t     m_tgt   [BHT_N];
    logic                     m_jump  [BHT_N];
    bpu_ctrl_pkg::dir_state_e m_ctr   [BHT_N];
    logic                     m_rp_valid [RPCT_N];
    bpu_types_pkg::addr_t     m_rp_pc    [RPCT_N];
    bpu_types_pkg::addr_t     m_stack[$];

    tb_clk_gen #(.PERIOD_NS(4.0), .RESET_CYCLES(16)) u_clk (.clk(clk), .rst_n(rst_n));

    bpu #(
        .COUNTER_BITS (2),
        .BHT_ENTRIES  (BHT_N),
        .RAS_DEPTH    (RAS_N),
        .RPCT_ENTRIES (RPCT_N)
    ) u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .f1_pc        (f1_pc),
        .jr_ra_decode (jr_ra_decode),
        .exe_pc       (exe_pc),
        .dest_pc      (dest_pc),
        .ret_pc       (ret_pc),
        .exe_kind     (exe_kind),
        .is_taken     (is_taken),
        .f1_taken     (f1_taken),
        .pos          (pos),
        .pre_pc       (pre_pc),
        .jr_ra_fail   (jr_ra_fail)
    );

    function automatic logic [31:0] next_rand();
        rand_state = rand_state ^ (rand_state << 13);
        rand_state = rand_state ^ (rand_state >> 17);
        rand_state = rand_state ^ (rand_state << 5);
        return rand_state;
    endfunction

    function automatic logic bht_holds(input bpu_types_pkg::addr_t pc);
        int unsigned i;
        i = (pc >> 2) % BHT_N;
        return m_valid[i] && ((m_pc[i] >> 2) == (pc >> 2));
    endfunction

    function automatic logic rpct_holds(input bpu_types_pkg::addr_t pc);
        int unsigned i;
        i = (pc >> 2) % RPCT_N;
        return m_rp_valid[i] && ((m_rp_pc[i] >> 2) == (pc >> 2));
    endfunction

    function automatic void predict(input step_t s, output logic taken, output logic p,
                                    output bpu_types_pkg::addr_t pre, output logic fail);
        logic b0, b1, r0, r1;
        int unsigned bi;
        bpu_types_pkg::addr_t top;
        b0 = bht_holds(s.f1_pc);
        b1 = bht_holds(s.f1_pc + 4);
        r0 = rpct_holds(s.f1_pc);
        r1 = rpct_holds(s.f1_pc + 4);
        bi = b0 ? (s.f1_pc >> 2) % BHT_N : ((s.f1_pc + 4) >> 2) % BHT_N;
        top = (m_stack.size() == 0) ? '0 : m_stack[m_stack.size() - 1];
        fail = (s.dec || r0 || r1) && (m_stack.size() == 0);
        pre = '0;
        if (s.dec) pre = top;
        else if (b0 || b1) pre = m_tgt[bi];
        else if (r0 || r1) pre = top;
        p = (b0 || b1) ? b0 : r0;
        taken = 1'b0;
        if ((r0 || r1) && !fail) taken = 1'b1;
        else if (b0 || b1) taken = m_jump[bi] ||
            (m_ctr[bi] inside {bpu_ctrl_pkg::WEAK_TAKEN, bpu_ctrl_pkg::STRONG_TAKEN});
    endfunction

    // State change at the edge that ends the step.
    function automatic void commit(input step_t s);
        logic pop, push;
        int unsigned i;
        pop  = s.dec || rpct_holds(s.f1_pc) || rpct_holds(s.f1_pc + 4);
        push = (s.kind == bpu_ctrl_pkg::XFER_JAL) || (s.kind == bpu_ctrl_pkg::XFER_JALR);
        if (push && pop && m_stack.size() != 0) begin
            m_stack[m_stack.size() - 1] = s.ret_pc; // Swap keeps the depth.
        end else if (push) begin
            if (m_stack.size() == RAS_N) void'(m_stack.pop_front());
            m_stack.push_back(s.ret_pc);
        end else if (pop && m_stack.size() != 0) begin
            void'(m_stack.pop_back());
        end
        if (s.kind inside {bpu_ctrl_pkg::XFER_BRANCH, bpu_ctrl_pkg::XFER_J,
                           bpu_ctrl_pkg::XFER_JAL}) begin
            i = (s.exe_pc >> 2) % BHT_N;
            if (s.kind != bpu_ctrl_pkg::XFER_BRANCH) m_ctr[i] = bpu_ctrl_pkg::STRONG_TAKEN;
            else if (!bht_holds(s.exe_pc))
                m_ctr[i] = s.taken ? bpu_ctrl_pkg::WEAK_TAKEN : bpu_ctrl_pkg::WEAK_NOT_TAKEN;
            else if (s.taken && m_ctr[i] != bpu_ctrl_pkg::STRONG_TAKEN)
                m_ctr[i] = bpu_ctrl_pkg::dir_state_e'(m_ctr[i] + 1);
            else if (!s.taken && m_ctr[i] != bpu_ctrl_pkg::STRONG_NOT_TAKEN)
                m_ctr[i] = bpu_ctrl_pkg::dir_state_e'(m_ctr[i] - 1);
            m_valid[i] = 1'b1;
            m_pc[i]    = s.exe_pc;
            m_tgt[i]   = s.dest_pc;
            m_jump[i]  = (s.kind != bpu_ctrl_pkg::XFER_BRANCH);
        end
        if (s.kind == bpu_ctrl_pkg::XFER_JR_RA) begin
            i = (s.exe_pc >> 2) % RPCT_N;
            m_rp_valid[i] = 1'b1;
            m_rp_pc[i]    = s.exe_pc;
        end
    endfunction

    task automatic add_step(input bpu_types_pkg::addr_t pc, input logic dec,
                            input bpu_ctrl_pkg::xfer_kind_e kind, input bpu_types_pkg::addr_t epc,
                            input bpu_types_pkg::addr_t dest, input bpu_types_pkg::addr_t ret,
                            input logic tk, input logic model, input logic et, input logic ep,
                            input bpu_types_pkg::addr_t epre, input logic ef);
        steps.push_back('{pc, dec, epc, dest, ret, kind, tk, model, et, ep, epre, ef});
    endtask

    task automatic model_step(input bpu_types_pkg::addr_t pc, input bpu_ctrl_pkg::xfer_kind_e kind,
                              input bpu_types_pkg::addr_t epc, input bpu_types_pkg::addr_t dest,
                              input bpu_types_pkg::addr_t ret, input logic tk);
        add_step(pc, 1'b0, kind, epc, dest, ret, tk, 1'b1, 1'b0, 1'b0, '0, 1'b0);
    endtask

    task automatic fixed_step(input bpu_types_pkg::addr_t pc, input logic dec, input logic et,
                              input logic ep, input bpu_types_pkg::addr_t epre, input logic ef);
        add_step(pc, dec, bpu_ctrl_pkg::XFER_NONE, '0, '0, '0, 1'b0, 1'b0, et, ep, epre, ef);
    endtask

    task automatic build_table();
        for (int n = 0; n < 20; n++) fixed_step(next_rand() & 32'hFFFF_FFFC, 1'b0, 0, 0, '0, 0);
        // Branch counter walk, then a plain lookup.
        model_step(32'h1000, bpu_ctrl_pkg::XFER_BRANCH, 32'h1000, 32'h2000, '0, 1'b1);
        model_step(32'h1000, bpu_ctrl_pkg::XFER_BRANCH, 32'h1000, 32'h2000, '0, 1'b1);
        model_step(32'h1000, bpu_ctrl_pkg::XFER_BRANCH, 32'h1000, 32'h2000, '0, 1'b0);
        model_step(32'h1000, bpu_ctrl_pkg::XFER_BRANCH, 32'h1000, 32'h2000, '0, 1'b0);
        model_step(32'h1000, bpu_ctrl_pkg::XFER_BRANCH, 32'h1000, 32'h2000, '0, 1'b0);
        model_step(32'h1000, bpu_ctrl_pkg::XFER_NONE, '0, '0, '0, 1'b0);
        fixed_step(32'h1000, 1'b0, 0, 1, 32'h2000, 0); // Strong not taken by now.
        model_step(IDLE, bpu_ctrl_pkg::XFER_J, 32'h1110, 32'h4000, '0, 1'b1);
        fixed_step(32'h1110, 1'b0, 1, 1, 32'h4000, 0);
        fixed_step(32'h110C, 1'b0, 1, 0, 32'h4000, 0);
        model_step(IDLE, bpu_ctrl_pkg::XFER_J, 32'h1114, 32'h4400, '0, 1'b1);
        fixed_step(32'h1110, 1'b0, 1, 1, 32'h4000, 0); // Both slots hold jumps.
        fixed_step(32'h1114, 1'b0, 1, 1, 32'h4400, 0);
        model_step(IDLE, bpu_ctrl_pkg::XFER_JAL, 32'h3000, 32'h5000, 32'hA004, 1'b1);
        model_step(IDLE, bpu_ctrl_pkg::XFER_JAL, 32'h3004, 32'h5000, 32'hA104, 1'b1);
        model_step(IDLE, bpu_ctrl_pkg::XFER_JAL, 32'h3008, 32'h5000, 32'hA204, 1'b1);
        fixed_step(IDLE, 1'b1, 0, 0, 32'hA204, 0);
        fixed_step(IDLE, 1'b1, 0, 0, 32'hA104, 0);
        fixed_step(IDLE, 1'b1, 0, 0, 32'hA004, 0);
        fixed_step(IDLE, 1'b1, 0, 0, '0, 1);
        // Return site learned in execute, then predicted in fetch.
        model_step(IDLE, bpu_ctrl_pkg::XFER_JR_RA, 32'h6010, '0, '0, 1'b1);
        model_step(IDLE, bpu_ctrl_pkg::XFER_JAL, 32'h7000, 32'h5000, 32'h7004, 1'b1);
        fixed_step(32'h6010, 1'b0, 1, 1, 32'h7004, 0);
        fixed_step(32'h6010, 1'b0, 0, 1, '0, 1);
        model_step(IDLE, bpu_ctrl_pkg::XFER_JAL, 32'h7100, 32'h5000, 32'h7104, 1'b1);
        fixed_step(32'h600C, 1'b0, 1, 0, 32'h7104, 0);
        model_step(IDLE, bpu_ctrl_pkg::XFER_JAL, 32'h3100, 32'h5000, 32'hB004, 1'b1);
        model_step(IDLE, bpu_ctrl_pkg::XFER_JAL, 32'h3200, 32'h5000, 32'hB104, 1'b1);
        add_step(IDLE, 1'b1, bpu_ctrl_pkg::XFER_JAL, 32'h3300, 32'h5000, 32'hB204, 1'b1,
                 1'b0, 1'b0, 1'b0, 32'hB104, 1'b0);
        fixed_step(IDLE, 1'b1, 0, 0, 32'hB204, 0);
        fixed_step(IDLE, 1'b1, 0, 0, 32'hB004, 0);
        fixed_step(IDLE, 1'b1, 0, 0, '0, 1);
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %0t step %0d %s: got %h, expected %h",
                     $time, cur_step, name, got, exp);
        end
    endtask

    initial begin
        int unsigned waited;
        logic e_taken, e_pos, e_fail;
        bpu_types_pkg::addr_t e_pre;
        f1_pc        = '0;
        jr_ra_decode = 1'b0;
        exe_pc       = '0;
        dest_pc      = '0;
        ret_pc       = '0;
        exe_kind     = bpu_ctrl_pkg::XFER_NONE;
        is_taken     = 1'b0;
        for (int i = 0; i < BHT_N; i++) begin
            m_valid[i] = 1'b0;
            m_ctr[i]   = bpu_ctrl_pkg::WEAK_NOT_TAKEN;
        end
        for (int i = 0; i < RPCT_N; i++) m_rp_valid[i] = 1'b0;
        build_table();
        waited = 0;
        while (rst_n !== 1'b1 && waited < RESET_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            $display("Timeout: reset still asserted after %0d cycles", waited);
            errors++;
        end else begin
            for (cur_step = 0; cur_step < steps.size(); cur_step++) begin
                #1;
                f1_pc        = steps[cur_step].f1_pc;
                jr_ra_decode = steps[cur_step].dec;
                exe_pc       = steps[cur_step].exe_pc;
                dest_pc      = steps[cur_step].dest_pc;
                ret_pc       = steps[cur_step].ret_pc;
                exe_kind     = steps[cur_step].kind;
                is_taken     = steps[cur_step].taken;
                #2; // Sample 1 ns before the next edge.
                predict(steps[cur_step], e_taken, e_pos, e_pre, e_fail);
                if (!steps[cur_step].from_model) begin
                    e_taken = steps[cur_step].exp_taken;
                    e_pos   = steps[cur_step].exp_pos;
                    e_pre   = steps[cur_step].exp_pre;
                    e_fail  = steps[cur_step].exp_fail;
                end
                check_field("f1_taken", f1_taken, e_taken);
                check_field("pos", pos, e_pos);
                check_field("pre_pc", pre_pc, e_pre);
                check_field("jr_ra_fail", jr_ra_fail, e_fail);
                commit(steps[cur_step]);
                @(posedge clk);
            end
        end
        $display("Steps: %0d, checks: %0d, errors: %0d", steps.size(), checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
logic/bpu_types_pkg.sv
logic/bpu_ctrl_pkg.sv
logic/bpu_update_if.sv
logic/bht.sv
logic/ras.sv
logic/rpct.sv
logic/bpu.sv
testbench/tb_clk_gen.sv
testbench/tb_bpu.sv

// ==== Bender.yml ====
package:
  name: bpu

sources:
  - logic/bpu_types_pkg.sv
  - logic/bpu_ctrl_pkg.sv
  - logic/bpu_update_if.sv
  - logic/bht.sv
  - logic/ras.sv
  - logic/rpct.sv
  - logic/bpu.sv
  - target: simulation
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_bpu.sv
